/* design/sao_pkg.sv */
/* SAO mode package: pixel, window, mask and index types shared by the
   edge-offset and band-offset classifiers and their controller */
package sao_pkg;

    // ------------------------------------------------------------
    // widths
    // ------------------------------------------------------------
    localparam int PIX_W      = 8;                // pixel bit depth
    localparam int BLK_N      = 4;                // block side
    localparam int WIN_N      = 6;                // block plus one-pixel border
    localparam int PIX_N      = BLK_N * BLK_N;    // flags per mask
    localparam int BAND_W     = 5;                // 32 bands
    localparam int BAND_SHIFT = PIX_W - BAND_W;   // low bits dropped for band number
    localparam int BLK_IDX_W  = 4;                // block index inside a CTB
    localparam int EO_CAT_N   = 4;                // edge categories
    localparam int BO_BAND_N  = 8;                // bands per group

    // ------------------------------------------------------------
    // vector types
    // ------------------------------------------------------------
    typedef logic [PIX_W-1:0]       pix_t;
    typedef logic [WIN_N*PIX_W-1:0] win_line_t;   // pixel 0 (leftmost) in low bits

    // bit index is row*4 + col, row 0 is window line 1, col 0 is window column 1
    typedef logic [PIX_N-1:0]       pix_mask_t;

    typedef logic [BAND_W-1:0]      band_t;
    typedef logic [BLK_IDX_W-1:0]   blk_idx_t;

    // ------------------------------------------------------------
    // enums
    // ------------------------------------------------------------
    typedef enum logic [1:0] {
        COMP_Y = 2'd0,
        COMP_U = 2'd1,
        COMP_V = 2'd2
    } sao_comp_e;

    typedef enum logic [1:0] {
        EO_0   = 2'd0,
        EO_45  = 2'd1,
        EO_90  = 2'd2,
        EO_135 = 2'd3
    } eo_dir_e;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,   // waiting for req
        ST_CALC = 2'd1,   // window registered, classifiers settling
        ST_ACK  = 2'd2    // masks valid, waiting for req to drop
    } ctrl_state_e;

endpackage

/* design/sao_edge_class.sv */
/* SAO edge-offset classifier for one direction: compares every block pixel
   with its two neighbors along DIR and sorts it into one of four categories */
`timescale 1ns/1ps

module sao_edge_class #(
    parameter sao_pkg::eo_dir_e DIR = sao_pkg::EO_0
) (
    input  sao_pkg::win_line_t line_i     [sao_pkg::WIN_N],
    output sao_pkg::pix_mask_t cat_mask_o [sao_pkg::EO_CAT_N]
);
    import sao_pkg::*;

    // ------------------------------------------------------------
    // neighbor offsets, a is the first neighbor and b mirrors it
    // ------------------------------------------------------------
    //   0   : a left,        b right
    //   45  : a upper right, b lower left
    //   90  : a above,       b below
    //   135 : a upper left,  b lower right
    localparam int DY = (DIR == EO_0) ? 0 : -1;
    localparam int DX = (DIR == EO_0)   ? -1 :
                        (DIR == EO_45)  ?  1 :
                        (DIR == EO_90)  ?  0 : -1;

    pix_t      pix [WIN_N][WIN_N];   // pix[line][column]

    pix_mask_t gt_a;   // neighbor a > center
    pix_mask_t eq_a;   // neighbor a = center
    pix_mask_t lt_a;
    pix_mask_t gt_b;
    pix_mask_t eq_b;
    pix_mask_t lt_b;

    // unpack window lines into a pixel grid
    always_comb begin
        for (int y = 0; y < WIN_N; y++) begin
            for (int x = 0; x < WIN_N; x++) begin
                pix[y][x] = line_i[y][x*PIX_W +: PIX_W];
            end
        end
    end

    // ------------------------------------------------------------
    // per-pixel neighbor compares
    // ------------------------------------------------------------
    for (genvar r = 0; r < BLK_N; r++) begin : g_row
        for (genvar c = 0; c < BLK_N; c++) begin : g_col
            localparam int CY  = r + 1;   // center in window coordinates
            localparam int CX  = c + 1;
            localparam int BIT = r * BLK_N + c;

            assign gt_a[BIT] = pix[CY+DY][CX+DX] >  pix[CY][CX];
            assign eq_a[BIT] = pix[CY+DY][CX+DX] == pix[CY][CX];
            assign gt_b[BIT] = pix[CY-DY][CX-DX] >  pix[CY][CX];
            assign eq_b[BIT] = pix[CY-DY][CX-DX] == pix[CY][CX];
        end
    end

    assign lt_a = ~gt_a & ~eq_a;   // neither greater nor equal
    assign lt_b = ~gt_b & ~eq_b;

    // ------------------------------------------------------------
    // categories
    // ------------------------------------------------------------
    // local minimum
    assign cat_mask_o[0] = gt_a & gt_b;
    // concave corner
    assign cat_mask_o[1] = (gt_a & eq_b) | (eq_a & gt_b);
    // convex corner
    assign cat_mask_o[2] = (eq_a & lt_b) | (lt_a & eq_b);
    // local maximum
    assign cat_mask_o[3] = lt_a & lt_b;

endmodule

/* design/sao_band_class.sv */
/* SAO band-offset classifier: places every block pixel in one of eight
   band masks counted from the pre-decided start band */
`timescale 1ns/1ps

module sao_band_class (
    input  sao_pkg::win_line_t line_i      [sao_pkg::WIN_N],
    input  sao_pkg::band_t     bo_start_i,
    output sao_pkg::pix_mask_t band_mask_o [sao_pkg::BO_BAND_N]
);
    import sao_pkg::*;

    band_t band_off [PIX_N];   // band number relative to start, mod 32

    // ------------------------------------------------------------
    // band offset per block pixel
    // ------------------------------------------------------------
    for (genvar r = 0; r < BLK_N; r++) begin : g_row
        for (genvar c = 0; c < BLK_N; c++) begin : g_col
            localparam int LINE = r + 1;                       // skip top border
            localparam int LSB  = (c + 1) * PIX_W + BAND_SHIFT; // upper bits of pixel

            assign band_off[r*BLK_N + c] = line_i[LINE][LSB +: BAND_W] - bo_start_i;
        end
    end

    // ------------------------------------------------------------
    // one-hot spread over the eight masks
    // ------------------------------------------------------------
    always_comb begin
        for (int b = 0; b < BO_BAND_N; b++) begin
            band_mask_o[b] = '0;
            for (int p = 0; p < PIX_N; p++) begin
                // offsets 8..31 alias onto the group, the SAO search picks the group
                band_mask_o[b][p] = (band_off[p][2:0] == b[2:0]);
            end
        end
    end

endmodule

/* design/sao_mode_top.sv */
/* SAO mode classifier top: four-phase req/ack controller around the edge and
   band classifiers, with CTB boundary gating and registered mask outputs */
`timescale 1ns/1ps

module sao_mode_top #(
    parameter int CTB_BLK_LAST = 15   // last luma 4x4 index in a CTB
) (
    input  logic                clk,
    input  logic                reset_i,

    input  logic                req_i,
    output logic                ack_o,

    input  sao_pkg::win_line_t  line_i     [sao_pkg::WIN_N],
    input  sao_pkg::blk_idx_t   blk_x_i,
    input  sao_pkg::blk_idx_t   blk_y_i,
    input  sao_pkg::sao_comp_e  comp_i,
    input  sao_pkg::band_t      bo_start_i,

    output sao_pkg::pix_mask_t  eo_mask_o  [4][sao_pkg::EO_CAT_N],
    output sao_pkg::pix_mask_t  bo_mask_o  [sao_pkg::BO_BAND_N]
);
    import sao_pkg::*;

    localparam blk_idx_t LUMA_LAST   = blk_idx_t'(CTB_BLK_LAST);
    localparam blk_idx_t CHROMA_LAST = blk_idx_t'((CTB_BLK_LAST + 1) / 2 - 1);

    // rows 0 and 1 sit in bits 7:0 of the row-major mask
    localparam pix_mask_t TOP_ROWS   = pix_mask_t'((1 << (2 * BLK_N)) - 1);

    // ------------------------------------------------------------
    // declarations
    // ------------------------------------------------------------
    ctrl_state_e state_q;

    win_line_t   line_q     [WIN_N];   // request fields, held for the classifiers
    blk_idx_t    blk_x_q;
    blk_idx_t    blk_y_q;
    sao_comp_e   comp_q;
    band_t       bo_start_q;

    pix_mask_t   eo_raw     [4][EO_CAT_N];   // ungated classifier outputs
    pix_mask_t   bo_raw     [BO_BAND_N];

    logic        blk_last;    // block on last CTB column or row
    pix_mask_t   keep_mask;   // pixels that survive gating

    // ------------------------------------------------------------
    // handshake FSM
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
            ack_o   <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (req_i) begin
                        state_q <= ST_CALC;   // fields captured this edge
                    end
                end
                ST_CALC: begin
                    state_q <= ST_ACK;        // masks captured this edge
                    ack_o   <= 1'b1;
                end
                ST_ACK: begin
                    if (!req_i) begin
                        state_q <= ST_IDLE;
                        ack_o   <= 1'b0;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                    ack_o   <= 1'b0;
                end
            endcase
        end
    end

    // request capture, only when a new request is accepted
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && req_i) begin
            line_q     <= line_i;
            blk_x_q    <= blk_x_i;
            blk_y_q    <= blk_y_i;
            comp_q     <= comp_i;
            bo_start_q <= bo_start_i;
        end
    end

    // ------------------------------------------------------------
    // classifiers
    // ------------------------------------------------------------
    sao_edge_class #(.DIR(EO_0)) u_eo_0 (
        .line_i     (line_q),
        .cat_mask_o (eo_raw[EO_0])
    );

    sao_edge_class #(.DIR(EO_45)) u_eo_45 (
        .line_i     (line_q),
        .cat_mask_o (eo_raw[EO_45])
    );

    sao_edge_class #(.DIR(EO_90)) u_eo_90 (
        .line_i     (line_q),
        .cat_mask_o (eo_raw[EO_90])
    );

    sao_edge_class #(.DIR(EO_135)) u_eo_135 (
        .line_i     (line_q),
        .cat_mask_o (eo_raw[EO_135])
    );

    sao_band_class u_bo (
        .line_i      (line_q),
        .bo_start_i  (bo_start_q),
        .band_mask_o (bo_raw)
    );

    // ------------------------------------------------------------
    // boundary gating
    // ------------------------------------------------------------
    always_comb begin
        case (comp_q)
            COMP_Y:         blk_last = (blk_x_q == LUMA_LAST)   || (blk_y_q == LUMA_LAST);
            COMP_U, COMP_V: blk_last = (blk_x_q == CHROMA_LAST) || (blk_y_q == CHROMA_LAST);
            default:        blk_last = 1'b1;   // unknown component, no masks
        endcase
    end

    // the bottom rows of a row-0 block are left for the next pass to classify
    assign keep_mask = blk_last        ? '0       :
                       (blk_y_q == '0) ? TOP_ROWS : '1;

    // ------------------------------------------------------------
    // output registers
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int d = 0; d < 4; d++) begin
                for (int c = 0; c < EO_CAT_N; c++) begin
                    eo_mask_o[d][c] <= '0;
                end
            end
            for (int b = 0; b < BO_BAND_N; b++) begin
                bo_mask_o[b] <= '0;
            end
        end else if (state_q == ST_CALC) begin   // held until the next request
            for (int d = 0; d < 4; d++) begin
                for (int c = 0; c < EO_CAT_N; c++) begin
                    eo_mask_o[d][c] <= eo_raw[d][c] & keep_mask;
                end
            end
            for (int b = 0; b < BO_BAND_N; b++) begin
                bo_mask_o[b] <= bo_raw[b] & keep_mask;
            end
        end
    end

endmodule

/* testbench/sao_mode_chk.sv */
/* SAO mode handshake checker: reset, ack and mask-hold rules of the
   four-phase interface, bound into the top level */
`timescale 1ns/1ps

module sao_mode_chk (
    input logic                 clk,
    input logic                 reset_i,
    input logic                 req_i,
    input logic                 ack_i,
    input sao_pkg::ctrl_state_e state_i,
    input sao_pkg::pix_mask_t   eo_mask_i [4][sao_pkg::EO_CAT_N],
    input sao_pkg::pix_mask_t   bo_mask_i [sao_pkg::BO_BAND_N]
);
    import sao_pkg::*;

    logic [(4*EO_CAT_N+BO_BAND_N)*PIX_N-1:0] mask_flat;   // all outputs side by side
    int assert_fail_n = 0;

    always_comb begin
        for (int d = 0; d < 4; d++) begin
            for (int k = 0; k < EO_CAT_N; k++) begin
                mask_flat[(d*EO_CAT_N+k)*PIX_N +: PIX_N] = eo_mask_i[d][k];
            end
        end
        for (int b = 0; b < BO_BAND_N; b++) begin
            mask_flat[(4*EO_CAT_N+b)*PIX_N +: PIX_N] = bo_mask_i[b];
        end
    end

    // ------------------------------------------------------------
    // handshake rules
    // ------------------------------------------------------------
    ack_low_in_reset: assert property (@(posedge clk) reset_i |=> !ack_i)
        else begin
            $error("ack high after a reset cycle");
            assert_fail_n++;
        end

    ack_needs_req: assert property (@(posedge clk) disable iff (reset_i)
        $rose(ack_i) |-> $past(req_i))
        else begin
            $error("ack rose without a request");
            assert_fail_n++;
        end

    masks_hold: assert property (@(posedge clk) disable iff (reset_i)
        ack_i ##1 ack_i |-> $stable(mask_flat))
        else begin
            $error("mask outputs changed while ack high");
            assert_fail_n++;
        end

    ack_drop: assert property (@(posedge clk) disable iff (reset_i)
        (state_i == ST_ACK && !req_i) |=> !ack_i)
        else begin
            $error("ack stayed high after req dropped");
            assert_fail_n++;
        end

endmodule

bind sao_mode_top sao_mode_chk u_chk (
    .clk       (clk),
    .reset_i   (reset_i),
    .req_i     (req_i),
    .ack_i     (ack_o),
    .state_i   (state_q),
    .eo_mask_i (eo_mask_o),
    .bo_mask_i (bo_mask_o)
);

/* testbench/tb_sao_mode.sv */
/* SAO mode classifier testbench: directed four-phase transactions checked
   against a behavioral model of the edge, band and gating rules */
`timescale 1ns/1ps

module tb_sao_mode;
    import sao_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int TXN_N        = 36;   // transactions over all tests
    localparam int WATCHDOG_NS  = (TXN_N * 20 + RESET_CYCLES) * CLK_PERIOD;
    localparam int ACK_LIMIT    = 10;   // edges allowed before ack
    localparam int HOLD_CYCLES  = 2;    // edges req stays high after ack

    logic       clk;
    logic       reset;
    logic       req;
    logic       ack;
    win_line_t  win      [WIN_N];
    blk_idx_t   blk_x;
    blk_idx_t   blk_y;
    sao_comp_e  comp;
    band_t      bo_start;
    pix_mask_t  eo_mask  [4][EO_CAT_N];
    pix_mask_t  bo_mask  [BO_BAND_N];

    pix_mask_t  exp_eo   [4][EO_CAT_N];   // model results
    pix_mask_t  exp_bo   [BO_BAND_N];

    integer     seed;
    int         err_count;
    int         test_pass;
    int         test_fail;

    sao_mode_top uut (
        .clk        (clk),
        .reset_i    (reset),
        .req_i      (req),
        .ack_o      (ack),
        .line_i     (win),
        .blk_x_i    (blk_x),
        .blk_y_i    (blk_y),
        .comp_i     (comp),
        .bo_start_i (bo_start),
        .eo_mask_o  (eo_mask),
        .bo_mask_o  (bo_mask)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    function automatic pix_t pix_at(int y, int x);
        return win[y][x*PIX_W +: PIX_W];
    endfunction

    // category of center c against neighbors a and b or -1 when none applies
    function automatic int edge_cat(pix_t a, pix_t b, pix_t c);
        if (a > c && b > c) return 0;
        if ((a > c && b == c) || (a == c && b > c)) return 1;
        if ((a == c && b < c) || (a < c && b == c)) return 2;
        if (a < c && b < c) return 3;
        return -1;
    endfunction

    function automatic void model_masks();
        int        y;
        int        x;
        int        bitn;
        int        cat;
        int        off;
        int        last;
        pix_t      cen;
        pix_mask_t keep;

        for (int d = 0; d < 4; d++) begin
            for (int k = 0; k < EO_CAT_N; k++) begin
                exp_eo[d][k] = '0;
            end
        end
        for (int b = 0; b < BO_BAND_N; b++) begin
            exp_bo[b] = '0;
        end
        for (int r = 0; r < BLK_N; r++) begin
            for (int c = 0; c < BLK_N; c++) begin
                y    = r + 1;   // window coordinates
                x    = c + 1;
                bitn = r * BLK_N + c;
                cen  = pix_at(y, x);
                for (int d = 0; d < 4; d++) begin
                    case (d)
                        0: cat = edge_cat(pix_at(y, x - 1), pix_at(y, x + 1), cen);
                        1: cat = edge_cat(pix_at(y - 1, x + 1), pix_at(y + 1, x - 1), cen);
                        2: cat = edge_cat(pix_at(y - 1, x), pix_at(y + 1, x), cen);
                        default: cat = edge_cat(pix_at(y - 1, x - 1), pix_at(y + 1, x + 1), cen);
                    endcase
                    if (cat >= 0) begin
                        exp_eo[d][cat][bitn] = 1'b1;
                    end
                end
                off = ((int'(cen) >> BAND_SHIFT) - int'(bo_start)) & 31;
                exp_bo[off % BO_BAND_N][bitn] = 1'b1;
            end
        end
        last = (comp == COMP_Y) ? 15 : 7;
        if (blk_x == last || blk_y == last) begin
            keep = '0;
        end else if (blk_y == 0) begin
            keep = 16'h00ff;   // bottom two rows dropped
        end else begin
            keep = 16'hffff;
        end
        for (int d = 0; d < 4; d++) begin
            for (int k = 0; k < EO_CAT_N; k++) begin
                exp_eo[d][k] &= keep;
            end
        end
        for (int b = 0; b < BO_BAND_N; b++) begin
            exp_bo[b] &= keep;
        end
    endfunction

    // ------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------
    task automatic check_mask(string name, pix_mask_t got, pix_mask_t want);
        if (got !== want) begin
            $display("ERROR %0t: %s got %h expected %h", $time, name, got, want);
            err_count++;
        end
    endtask

    task automatic check_bit(string name, logic got, logic want);
        if (got !== want) begin
            $display("ERROR %0t: %s got %b expected %b", $time, name, got, want);
            err_count++;
        end
    endtask

    task automatic check_count(string name, int got, int want);
        if (got != want) begin
            $display("ERROR %0t: %s got %0d expected %0d", $time, name, got, want);
            err_count++;
        end
    endtask

    task automatic check_outputs(string tag);
        for (int d = 0; d < 4; d++) begin
            for (int k = 0; k < EO_CAT_N; k++) begin
                check_mask($sformatf("%s eo[%0d][%0d]", tag, d, k), eo_mask[d][k], exp_eo[d][k]);
            end
        end
        for (int b = 0; b < BO_BAND_N; b++) begin
            check_mask($sformatf("%s bo[%0d]", tag, b), bo_mask[b], exp_bo[b]);
        end
    endtask

    // ------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------
    function automatic int rand_range(int lo, int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    task automatic set_random_window(int val_mask);
        for (int y = 0; y < WIN_N; y++) begin
            for (int x = 0; x < WIN_N; x++) begin
                win[y][x*PIX_W +: PIX_W] = pix_t'($random(seed) & val_mask);
            end
        end
    endtask

    task automatic set_block(sao_comp_e c, int x, int y, int start);
        comp     = c;
        blk_x    = blk_idx_t'(x);
        blk_y    = blk_idx_t'(y);
        bo_start = band_t'(start);
    endtask

    // one full four-phase transaction with the masks checked while ack is high
    task automatic run_request(string tag);
        int n;
        req = 1'b1;
        @(posedge clk);
        #1;
        check_bit($sformatf("%s ack one edge after req", tag), ack, 1'b0);
        n = 1;
        while (ack !== 1'b1 && n < ACK_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (ack !== 1'b1) begin
            $display("%s: no acknowledge within %0d cycles of the request, time %0t",
                     tag, ACK_LIMIT, $time);
            err_count++;
        end else begin
            check_count($sformatf("%s edges to ack", tag), n, 2);
            check_outputs(tag);
            // slow requester keeps the top in ST_ACK
            repeat (HOLD_CYCLES) begin
                @(posedge clk);
                #1;
                check_bit($sformatf("%s ack while req held", tag), ack, 1'b1);
            end
            check_outputs($sformatf("%s held", tag));
        end
        req = 1'b0;
        @(posedge clk);
        #1;
        check_bit($sformatf("%s ack after req release", tag), ack, 1'b0);
    endtask

    task automatic finish_test(string name, int errs_before);
        if (err_count == errs_before) begin
            test_pass++;
            $display("%s: pass", name);
        end else begin
            test_fail++;
            $display("%s: FAIL, %0d errors", name, err_count - errs_before);
        end
    endtask

    // ------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------
    task automatic test_reset_handshake();
        int errs;
        errs = err_count;
        check_bit("ack after reset", ack, 1'b0);
        for (int d = 0; d < 4; d++) begin
            for (int k = 0; k < EO_CAT_N; k++) begin
                check_mask($sformatf("reset eo[%0d][%0d]", d, k), eo_mask[d][k], '0);
            end
        end
        for (int b = 0; b < BO_BAND_N; b++) begin
            check_mask($sformatf("reset bo[%0d]", b), bo_mask[b], '0);
        end
        set_random_window(8'hff);
        set_block(COMP_Y, 6, 9, 12);
        model_masks();
        run_request("handshake");
        finish_test("reset and handshake", errs);
    endtask

    task automatic flat_case(pix_t val, int start);
        int band;
        for (int y = 0; y < WIN_N; y++) begin
            for (int x = 0; x < WIN_N; x++) begin
                win[y][x*PIX_W +: PIX_W] = val;
            end
        end
        set_block(COMP_Y, 3, 5, start);
        band = ((int'(val) >> BAND_SHIFT) - start) & 31;
        for (int d = 0; d < 4; d++) begin
            for (int k = 0; k < EO_CAT_N; k++) begin
                exp_eo[d][k] = '0;   // no edges in a flat area
            end
        end
        for (int b = 0; b < BO_BAND_N; b++) begin
            exp_bo[b] = (b == band % BO_BAND_N) ? 16'hffff : 16'h0000;
        end
        run_request($sformatf("flat %h", val));
    endtask

    task automatic test_flat_window();
        int errs;
        errs = err_count;
        flat_case(8'h5a, 9);
        flat_case(8'hff, 30);
        finish_test("flat window", errs);
    endtask

    task automatic test_random_edges();
        int errs;
        errs = err_count;
        for (int i = 0; i < 12; i++) begin
            set_random_window((i % 2) ? 8'h03 : 8'hff);   // narrow range gives ties
            set_block(COMP_Y, rand_range(1, 14), rand_range(1, 14), rand_range(0, 31));
            model_masks();
            run_request($sformatf("random edge %0d", i));
        end
        finish_test("random edge masks", errs);
    endtask

    task automatic test_band_wrap();
        int errs;
        errs = err_count;
        for (int i = 0; i < 10; i++) begin
            set_random_window(8'hff);
            set_block(COMP_Y, rand_range(1, 14), rand_range(1, 14),
                      (i < 3) ? 29 + i : rand_range(0, 31));
            model_masks();
            run_request($sformatf("band %0d start %0d", i, bo_start));
        end
        finish_test("band masks with wrap", errs);
    endtask

    task automatic boundary_case(sao_comp_e c, int x, int y);
        set_random_window(8'hff);
        set_block(c, x, y, rand_range(0, 31));
        model_masks();
        run_request($sformatf("boundary %s x%0d y%0d", c.name(), x, y));
    endtask

    task automatic test_boundary();
        int errs;
        errs = err_count;
        boundary_case(COMP_Y, 15, 5);
        boundary_case(COMP_Y, 4, 15);
        boundary_case(COMP_Y, 15, 15);
        boundary_case(COMP_U, 7, 3);
        boundary_case(COMP_V, 2, 7);
        boundary_case(COMP_Y, 7, 3);   // interior for luma
        boundary_case(COMP_V, 7, 5);
        finish_test("boundary gating", errs);
    endtask

    task automatic test_top_row();
        int errs;
        errs = err_count;
        for (int i = 0; i < 4; i++) begin
            set_random_window((i == 1) ? 8'h03 : 8'hff);
            if (i == 3) begin
                set_block(COMP_U, 3, 0, rand_range(0, 31));
            end else begin
                set_block(COMP_Y, rand_range(1, 14), 0, rand_range(0, 31));
            end
            model_masks();
            run_request($sformatf("top row %0d", i));
        end
        finish_test("block row zero", errs);
    endtask

    initial begin
        seed      = 32'he4b6_5e66;
        err_count = 0;
        test_pass = 0;
        test_fail = 0;
        reset     = 1'b1;
        req       = 1'b0;
        blk_x     = '0;
        blk_y     = '0;
        comp      = COMP_Y;
        bo_start  = '0;
        for (int y = 0; y < WIN_N; y++) begin
            win[y] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        test_reset_handshake();
        test_flat_window();
        test_random_edges();
        test_band_wrap();
        test_boundary();
        test_top_row();

        $display("tests passed %0d, failed %0d, check errors %0d, assertion failures %0d",
                 test_pass, test_fail, err_count, uut.u_chk.assert_fail_n);
        if (err_count == 0 && uut.u_chk.assert_fail_n == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* project.f */
design/sao_pkg.sv
design/sao_edge_class.sv
design/sao_band_class.sv
design/sao_mode_top.sv
testbench/sao_mode_chk.sv
testbench/tb_sao_mode.sv

/* Bender.yml */
package:
  name: sao_mode

sources:
  # synthesizable design, package first
  - files:
      - design/sao_pkg.sv
      - design/sao_edge_class.sv
      - design/sao_band_class.sv
      - design/sao_mode_top.sv

  # testbench and bound assertions
  - target: test
    files:
      - testbench/sao_mode_chk.sv
      - testbench/tb_sao_mode.sv
